// ==== vlog.f ====
+incdir+common
common/cpuCore_pkg.sv
source/handshakeStage.sv
decode/opcodeDecoder.sv
source/registerFile.sv
execute/logicUnit.sv
execute/cbUnit.sv
source/retireMerge.sv
source/cpuCore.sv
test/cpuCore_assertions.sv
test/cpuCore_tb.sv

// ==== Makefile ====
# Verilator build and run for the cpuCore testbench

VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = cpuCore_tb
FILELIST = vlog.f
BUILD_DIR = obj_dir
PASS_MSG = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Fails unless the pass message shows up as a line of its own
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== test/cpuCore_tb.sv ====
`timescale 1ns/1ps
`include "cpuCore_macros.svh"

module cpuCore_tb;

	localparam int seedValue = 32516;
	localparam int timeoutCycles = 1000;
	localparam int randomCount = 300; // Instructions in the back-pressure test
	localparam cpuCore_pkg::regIndexT hlSlot = cpuCore_pkg::regIndexT'(`REG_HL);
	localparam cpuCore_pkg::regIndexT accSlot = cpuCore_pkg::regIndexT'(`REG_A);

	logic iClock;
	logic rstN;
	cpuCore_pkg::dataT opcodeByte;
	logic opcodeValid;
	logic opcodeReady;
	cpuCore_pkg::retireT retire;
	logic retireValid;
	logic retireReady;

	cpuCore_pkg::dataT modelRegs [`REG_COUNT]; // Slot 6 stays unused
	cpuCore_pkg::dataT modelFlags;
	cpuCore_pkg::retireT expectQ [$];
	logic backPressure;
	int errorCount;
	int recordCount;

	cpuCore u_cpuCore
	(
		.iClock(iClock),
		.rstN(rstN),
		.opcodeByte(opcodeByte),
		.opcodeValid(opcodeValid),
		.opcodeReady(opcodeReady),
		.retire(retire),
		.retireValid(retireValid),
		.retireReady(retireReady)
	);

	initial
	begin
		iClock = 1'b0;
		forever #5 iClock = ~iClock;
	end

	// Output side stalls about one cycle in four when enabled
	initial
	begin : readyDriver
		retireReady = 1'b1;
		forever
		begin
			@(negedge iClock);
			retireReady = backPressure ? (($urandom % 4) != 0) : 1'b1;
		end
	end

	// ----------------------------------------------------------
	// Checking
	task automatic reportMismatch(input string name, input cpuCore_pkg::dataT got,
		input cpuCore_pkg::dataT exp);
		$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
		errorCount++;
	endtask

	task automatic checkRetire(input cpuCore_pkg::retireT got, input cpuCore_pkg::retireT exp);
		if (got.opcode !== exp.opcode)
			reportMismatch("retire.opcode", got.opcode, exp.opcode);
		if (got.cb !== exp.cb)
			reportMismatch("retire.cb", cpuCore_pkg::dataT'(got.cb), cpuCore_pkg::dataT'(exp.cb));
		if (got.illegal !== exp.illegal)
			reportMismatch("retire.illegal", cpuCore_pkg::dataT'(got.illegal),
				cpuCore_pkg::dataT'(exp.illegal));
		if (got.writeReg !== exp.writeReg)
			reportMismatch("retire.writeReg", cpuCore_pkg::dataT'(got.writeReg),
				cpuCore_pkg::dataT'(exp.writeReg));
		if (got.flags !== exp.flags)
			reportMismatch("retire.flags", got.flags, exp.flags);
		// Destination and value only matter when a register is written
		if (exp.writeReg)
		begin
			if (got.dst !== exp.dst)
				reportMismatch("retire.dst", cpuCore_pkg::dataT'(got.dst),
					cpuCore_pkg::dataT'(exp.dst));
			if (got.value !== exp.value)
				reportMismatch("retire.value", got.value, exp.value);
		end
	endtask

	always @(posedge iClock)
	begin : monitor
		cpuCore_pkg::retireT expected;
		if (rstN && retireValid && retireReady)
		begin
			recordCount++;
			if (expectQ.size() == 0)
			begin
				$display("A retire record arrived with no instruction outstanding");
				errorCount++;
			end
			else
			begin
				expected = expectQ.pop_front();
				checkRetire(retire, expected);
			end
		end
	end

	// ----------------------------------------------------------
	// Reference model, applied when an instruction is sent
	task automatic predict(input cpuCore_pkg::dataT first, input cpuCore_pkg::dataT second,
		output cpuCore_pkg::retireT exp);
		cpuCore_pkg::dataT operand;
		logic legal;
		exp = '0;
		exp.opcode = first;
		exp.flags = modelFlags;
		legal = 1'b0;
		if (first == `CB_PREFIX)
		begin
			exp.cb = 1'b1;
			exp.opcode = second;
			exp.dst = second[2:0];
			operand = modelRegs[second[2:0]];
			if (second[2:0] != hlSlot && second[7:3] == 5'b00010)
			begin
				legal = 1'b1; // RL r, old C into bit 0
				exp.value = {operand[6:0], modelFlags[`FLAG_C]};
				exp.writeReg = 1'b1;
				exp.flags = '0;
				exp.flags[`FLAG_C] = operand[7];
				exp.flags[`FLAG_Z] = (exp.value == 8'h00);
			end
			else if (second[2:0] != hlSlot && second[7:6] == 2'b01)
			begin
				legal = 1'b1; // BIT b,r
				exp.flags[`FLAG_Z] = !operand[second[5:3]];
			end
		end
		else if (first[7:6] == 2'b00 && first[2:0] == 3'b110)
		begin
			legal = (first[5:3] != hlSlot); // LD r,n
			exp.dst = first[5:3];
			exp.value = second;
			exp.writeReg = legal;
		end
		else if (first[7:6] == 2'b01)
		begin
			legal = (first[5:3] != hlSlot) && (first[2:0] != hlSlot);
			exp.dst = first[5:3];
			exp.value = modelRegs[first[2:0]];
			exp.writeReg = legal;
		end
		else if (first[7:4] == 4'hA && first[2:0] != hlSlot)
		begin
			legal = 1'b1;
			exp.dst = accSlot;
			exp.value = first[3] ? (modelRegs[accSlot] ^ modelRegs[first[2:0]])
				: (modelRegs[accSlot] & modelRegs[first[2:0]]);
			exp.writeReg = 1'b1;
			exp.flags = '0; // C cleared
			exp.flags[`FLAG_Z] = (exp.value == 8'h00);
		end
		exp.illegal = !legal;
		if (exp.writeReg)
			modelRegs[exp.dst] = exp.value;
		if (legal)
			modelFlags = exp.flags;
	endtask

	// ----------------------------------------------------------
	// Stimulus
	function automatic cpuCore_pkg::regIndexT randSlot();
		cpuCore_pkg::regIndexT slot;
		slot = cpuCore_pkg::regIndexT'($urandom % 7);
		if (slot == hlSlot)
			slot = accSlot; // Never (HL)
		return slot;
	endfunction

	function automatic cpuCore_pkg::dataT randByte();
		return cpuCore_pkg::dataT'($urandom);
	endfunction

	task automatic sendByte(input cpuCore_pkg::dataT value, inout bit ok);
		int waited;
		waited = 0;
		opcodeByte = value;
		opcodeValid = 1'b1;
		@(posedge iClock);
		while (!opcodeReady && waited < timeoutCycles)
		begin
			waited++;
			@(posedge iClock);
		end
		@(negedge iClock);
		opcodeValid = 1'b0;
		if (waited >= timeoutCycles)
		begin
			$display("Timeout: opcodeReady stayed low for %0d cycles", timeoutCycles);
			ok = 1'b0;
		end
	endtask

	task automatic issue(input cpuCore_pkg::dataT first, input cpuCore_pkg::dataT second,
		input bit twoBytes, inout bit ok);
		cpuCore_pkg::retireT exp;
		if (ok)
		begin
			predict(first, second, exp);
			expectQ.push_back(exp);
			sendByte(first, ok);
			if (twoBytes && ok)
				sendByte(second, ok);
		end
	endtask

	task automatic waitDrain(inout bit ok);
		int waited;
		waited = 0;
		if (ok)
		begin
			while (expectQ.size() != 0 && waited < timeoutCycles)
			begin
				waited++;
				@(negedge iClock);
			end
			if (expectQ.size() != 0)
			begin
				$display("Timeout: %0d retire records never arrived", expectQ.size());
				ok = 1'b0;
			end
		end
	endtask

	task automatic pickIllegal(output cpuCore_pkg::dataT first, output cpuCore_pkg::dataT second,
		output bit twoBytes);
		first = 8'h00;
		second = randByte();
		twoBytes = 1'b0;
		case ($urandom % 6)
			0: first = {2'b01, randSlot(), 3'b110}; // LD r,(HL)
			1: first = {5'b01110, 3'($urandom)}; // LD (HL),r and HALT
			2: first = ($urandom % 2) ? 8'hAE : 8'hA6;
			3:
			begin
				first = 8'h36; // LD (HL),n
				twoBytes = 1'b1;
			end
			4: first = ($urandom % 2) ? {3'b100, 5'($urandom)} : {4'hB, 4'($urandom)};
			default:
			begin
				first = `CB_PREFIX;
				twoBytes = 1'b1;
				case ($urandom % 4)
					0: second = {4'h0, 4'($urandom)}; // RLC, RRC
					1: second = {3'b001, 5'($urandom)}; // SLA and friends
					2: second = {1'b1, 7'($urandom)}; // RES, SET
					default: second = {2'b01, 3'($urandom), 3'b110}; // BIT b,(HL)
				endcase
			end
		endcase
	endtask

	task automatic pickRandom(output cpuCore_pkg::dataT first, output cpuCore_pkg::dataT second,
		output bit twoBytes);
		int weight;
		weight = int'($urandom % 100);
		first = {2'b01, randSlot(), randSlot()};
		second = randByte();
		twoBytes = 1'b0;
		if (weight >= 20 && weight < 40)
		begin
			first = {2'b00, randSlot(), 3'b110};
			twoBytes = 1'b1;
		end
		else if (weight >= 40 && weight < 65)
			first = {4'hA, 1'($urandom), randSlot()};
		else if (weight >= 65 && weight < 90)
		begin
			first = `CB_PREFIX;
			twoBytes = 1'b1;
			if (weight < 75)
				second = {5'b00010, randSlot()};
			else
				second = {2'b01, 3'($urandom), randSlot()};
		end
		else if (weight >= 90)
			pickIllegal(first, second, twoBytes);
	endtask

	// ----------------------------------------------------------
	// Tests
	task automatic loadTest(inout bit ok);
		if (retireValid !== 1'b0 || opcodeReady !== 1'b1)
		begin
			$display("Handshake outputs are not idle after reset");
			errorCount++;
		end
		for (int r = 0; r < `REG_COUNT; r++)
			if (r != `REG_HL)
				issue({2'b00, 3'(r), 3'b110}, randByte(), 1'b1, ok);
		for (int i = 0; i < 12; i++)
			issue({2'b01, randSlot(), randSlot()}, 8'h00, 1'b0, ok);
	endtask

	task automatic logicTest(inout bit ok);
		for (int i = 0; i < 24; i++)
		begin
			if (i % 4 == 0)
				issue({2'b00, accSlot, 3'b110}, randByte(), 1'b1, ok); // Fresh A
			issue({4'hA, 1'($urandom), randSlot()}, 8'h00, 1'b0, ok);
		end
	endtask

	task automatic rotateTest(inout bit ok);
		for (int r = 0; r < `REG_COUNT; r++)
			if (r != `REG_HL)
				issue({2'b00, 3'(r), 3'b110}, randByte(), 1'b1, ok);
		for (int pass = 0; pass < 4; pass++)
			for (int r = 0; r < `REG_COUNT; r++)
				if (r != `REG_HL)
					issue(`CB_PREFIX, {5'b00010, 3'(r)}, 1'b1, ok);
	endtask

	task automatic bitTestRun(inout bit ok);
		for (int i = 0; i < 24; i++)
		begin
			if (i % 3 == 0)
				issue(`CB_PREFIX, {5'b00010, randSlot()}, 1'b1, ok); // Moves C around
			issue(`CB_PREFIX, {2'b01, 3'($urandom), randSlot()}, 1'b1, ok);
		end
	endtask

	task automatic illegalTest(inout bit ok);
		cpuCore_pkg::dataT first;
		cpuCore_pkg::dataT second;
		bit twoBytes;
		for (int i = 0; i < 30; i++)
		begin
			pickIllegal(first, second, twoBytes);
			issue(first, second, twoBytes, ok);
		end
		// Self copies expose every register value
		for (int r = 0; r < `REG_COUNT; r++)
			if (r != `REG_HL)
				issue({2'b01, 3'(r), 3'(r)}, 8'h00, 1'b0, ok);
	endtask

	task automatic randomTest(inout bit ok);
		cpuCore_pkg::dataT first;
		cpuCore_pkg::dataT second;
		bit twoBytes;
		backPressure = 1'b1;
		for (int i = 0; i < randomCount; i++)
		begin
			pickRandom(first, second, twoBytes);
			issue(first, second, twoBytes, ok);
		end
		waitDrain(ok);
		backPressure = 1'b0;
	endtask

	task automatic runTest(input int number, inout bit ok);
		int startErrors;
		int startRecords;
		string name;
		startErrors = errorCount;
		startRecords = recordCount;
		name = "random with back-pressure";
		case (number)
			1:
			begin
				name = "load";
				loadTest(ok);
			end
			2:
			begin
				name = "and/xor";
				logicTest(ok);
			end
			3:
			begin
				name = "rotate";
				rotateTest(ok);
			end
			4:
			begin
				name = "bit";
				bitTestRun(ok);
			end
			5:
			begin
				name = "illegal";
				illegalTest(ok);
			end
			default: randomTest(ok);
		endcase
		waitDrain(ok);
		$display("Test %0d %s: %0d records, %0d errors", number, name,
			recordCount - startRecords, errorCount - startErrors);
	endtask

	initial
	begin : mainSequence
		bit ok;
		ok = 1'b1;
		void'($urandom(seedValue));
		rstN = 1'b0;
		opcodeByte = '0;
		opcodeValid = 1'b0;
		backPressure = 1'b0;
		errorCount = 0;
		recordCount = 0;
		modelFlags = '0;
		for (int r = 0; r < `REG_COUNT; r++)
			modelRegs[r] = '0;
		repeat (8) @(posedge iClock);
		@(negedge iClock);
		rstN = 1'b1;
		for (int t = 1; t <= 6; t++)
			if (ok)
				runTest(t, ok);
		$display("Records checked: %0d, errors: %0d, outstanding: %0d", recordCount,
			errorCount, expectQ.size());
		if (ok && errorCount == 0 && expectQ.size() == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== test/cpuCore_assertions.sv ====
`timescale 1ns/1ps
`include "cpuCore_macros.svh"

module cpuCore_assertions
(
	input logic iClock,
	input logic rstN,
	input cpuCore_pkg::dataT opcodeByte,
	input logic opcodeValid,
	input logic opcodeReady,
	input cpuCore_pkg::retireT retire,
	input logic retireValid,
	input logic retireReady,
	input logic writeEn,
	input cpuCore_pkg::regIndexT writeIdx,
	input cpuCore_pkg::dataT accData,
	input cpuCore_pkg::dataT flags
);

	// ----------------------------------------------------------
	// Streams hold valid and data until the transfer
	opcodeHold: assert property (@(posedge iClock) disable iff (!rstN)
		opcodeValid && !opcodeReady |=> opcodeValid && $stable(opcodeByte))
		else $error("Opcode byte dropped or changed while stalled");

	retireHold: assert property (@(posedge iClock) disable iff (!rstN)
		retireValid && !retireReady |=> retireValid && $stable(retire))
		else $error("Retire record dropped or changed while stalled");

	// State only moves when a record enters the retire stage
	noWriteStalled: assert property (@(posedge iClock) disable iff (!rstN)
		retireValid && !retireReady |=> $stable(accData) && $stable(flags))
		else $error("Accumulator or flags changed during an output stall");

	noHlWrite: assert property (@(posedge iClock) disable iff (!rstN)
		writeEn |-> writeIdx != cpuCore_pkg::regIndexT'(`REG_HL))
		else $error("Write to the (HL) slot");

endmodule

bind cpuCore cpuCore_assertions u_cpuCoreAssertions
(
	.iClock(iClock),
	.rstN(rstN),
	.opcodeByte(opcodeByte),
	.opcodeValid(opcodeValid),
	.opcodeReady(opcodeReady),
	.retire(retire),
	.retireValid(retireValid),
	.retireReady(retireReady),
	.writeEn(writeEn),
	.writeIdx(writeIdx),
	.accData(accData),
	.flags(flags)
);

// ==== source/cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore
(
	input logic iClock,
	input logic rstN,
	input cpuCore_pkg::dataT opcodeByte,
	input logic opcodeValid,
	output logic opcodeReady,
	output cpuCore_pkg::retireT retire,
	output logic retireValid,
	input logic retireReady
);

	cpuCore_pkg::uopT uop;
	logic uopValid;
	logic uopReady;
	cpuCore_pkg::dataT srcData;
	cpuCore_pkg::dataT accData;
	cpuCore_pkg::dataT flags;
	cpuCore_pkg::execResultT logicResult;
	cpuCore_pkg::execResultT cbResult;
	logic writeEn;
	cpuCore_pkg::regIndexT writeIdx;
	cpuCore_pkg::dataT writeData;
	logic flagsEn;
	cpuCore_pkg::dataT flagsData;

	opcodeDecoder u_opcodeDecoder
	(
		.iClock(iClock),
		.rstN(rstN),
		.opcodeByte(opcodeByte),
		.opcodeValid(opcodeValid),
		.opcodeReady(opcodeReady),
		.uop(uop),
		.uopValid(uopValid),
		.uopReady(uopReady)
	);

	// Operands read straight from the micro-op stage
	registerFile u_registerFile
	(
		.iClock(iClock),
		.rstN(rstN),
		.srcIdx(uop.src),
		.srcData(srcData),
		.accData(accData),
		.flags(flags),
		.writeEn(writeEn),
		.writeIdx(writeIdx),
		.writeData(writeData),
		.flagsEn(flagsEn),
		.flagsData(flagsData)
	);

	// ----------------------------------------------------------
	// Both units see the same micro-op
	logicUnit u_logicUnit
	(
		.uop(uop),
		.srcData(srcData),
		.accData(accData),
		.flags(flags),
		.result(logicResult)
	);

	cbUnit u_cbUnit
	(
		.uop(uop),
		.srcData(srcData),
		.flags(flags),
		.result(cbResult)
	);

	retireMerge u_retireMerge
	(
		.iClock(iClock),
		.rstN(rstN),
		.uop(uop),
		.uopValid(uopValid),
		.uopReady(uopReady),
		.logicResult(logicResult),
		.cbResult(cbResult),
		.writeEn(writeEn),
		.writeIdx(writeIdx),
		.writeData(writeData),
		.flagsEn(flagsEn),
		.flagsData(flagsData),
		.retire(retire),
		.retireValid(retireValid),
		.retireReady(retireReady)
	);

endmodule

// ==== source/retireMerge.sv ====
`timescale 1ns/1ps

module retireMerge
(
	input logic iClock,
	input logic rstN,
	input cpuCore_pkg::uopT uop,
	input logic uopValid,
	output logic uopReady,
	input cpuCore_pkg::execResultT logicResult,
	input cpuCore_pkg::execResultT cbResult,
	output logic writeEn,
	output cpuCore_pkg::regIndexT writeIdx,
	output cpuCore_pkg::dataT writeData,
	output logic flagsEn,
	output cpuCore_pkg::dataT flagsData,
	output cpuCore_pkg::retireT retire,
	output logic retireValid,
	input logic retireReady
);

	cpuCore_pkg::execResultT chosen;
	cpuCore_pkg::retireT record;
	logic isCbOp;
	logic isIllegal;
	logic load;

	assign isCbOp = (uop.kind == cpuCore_pkg::rl) || (uop.kind == cpuCore_pkg::bitTest);
	assign isIllegal = (uop.kind == cpuCore_pkg::illegal);
	assign chosen = isCbOp ? cbResult : logicResult;

	always_comb
	begin
		record.opcode = uop.opcode;
		record.cb = uop.cb;
		record.illegal = isIllegal;
		record.dst = uop.dst;
		record.value = chosen.value;
		record.flags = chosen.flags; // Unchanged flags when illegal
		record.writeReg = chosen.writeReg && !isIllegal;
	end

	// ----------------------------------------------------------
	// Write back on the loading edge only
	assign load = uopValid && uopReady;
	assign writeEn = load && record.writeReg;
	assign writeIdx = uop.dst;
	assign writeData = chosen.value;
	assign flagsEn = load && !isIllegal;
	assign flagsData = chosen.flags;

	handshakeStage #(.payloadT(cpuCore_pkg::retireT)) u_retireStage
	(
		.iClock(iClock),
		.rstN(rstN),
		.inData(record),
		.inValid(uopValid),
		.inReady(uopReady),
		.outData(retire),
		.outValid(retireValid),
		.outReady(retireReady)
	);

endmodule

// ==== execute/cbUnit.sv ====
`timescale 1ns/1ps
`include "cpuCore_macros.svh"

module cbUnit
(
	input cpuCore_pkg::uopT uop,
	input cpuCore_pkg::dataT srcData,
	input cpuCore_pkg::dataT flags,
	output cpuCore_pkg::execResultT result
);

	cpuCore_pkg::dataT bitMask;
	cpuCore_pkg::dataT rotated;
	cpuCore_pkg::dataT tested;

	// One-hot mask from the bit number
	assign bitMask = cpuCore_pkg::dataT'(1) << uop.bitSel;

	// Old carry enters at bit 0
	assign rotated = {srcData[`DATA_WIDTH-2:0], flags[`FLAG_C]};
	assign tested = srcData & bitMask;

	always_comb
	begin
		result.value = '0;
		result.flags = flags;
		result.writeReg = 1'b0;
		case (uop.kind)
			cpuCore_pkg::rl:
			begin
				result.value = rotated;
				result.flags = '0;
				result.flags[`FLAG_Z] = (rotated == '0);
				result.flags[`FLAG_C] = srcData[`DATA_WIDTH-1]; // Bit 7 goes to carry
				result.writeReg = 1'b1;
			end
			cpuCore_pkg::bitTest:
			begin
				result.value = tested;
				result.flags = '0;
				result.flags[`FLAG_Z] = (tested == '0);
				result.flags[`FLAG_C] = flags[`FLAG_C];
			end
			default:
			begin
				result.writeReg = 1'b0; // Not a CB op
			end
		endcase
	end

endmodule

// ==== execute/logicUnit.sv ====
`timescale 1ns/1ps
`include "cpuCore_macros.svh"

module logicUnit
(
	input cpuCore_pkg::uopT uop,
	input cpuCore_pkg::dataT srcData,
	input cpuCore_pkg::dataT accData,
	input cpuCore_pkg::dataT flags,
	output cpuCore_pkg::execResultT result
);

	cpuCore_pkg::dataT value;
	cpuCore_pkg::dataT logicFlags;
	logic logicOp; // AND or XOR, which rewrite the flags

	always_comb
	begin
		value = '0;
		case (uop.kind)
			cpuCore_pkg::ldReg: value = srcData;
			cpuCore_pkg::ldImm: value = uop.imm;
			cpuCore_pkg::andA: value = accData & srcData;
			cpuCore_pkg::xorA: value = accData ^ srcData;
			default: value = '0;
		endcase
	end

	assign logicOp = (uop.kind == cpuCore_pkg::andA) || (uop.kind == cpuCore_pkg::xorA);

	always_comb
	begin
		logicFlags = '0; // C cleared
		logicFlags[`FLAG_Z] = (value == '0);
	end

	assign result.value = value;
	assign result.flags = logicOp ? logicFlags : flags; // LD leaves flags alone
	assign result.writeReg = logicOp || (uop.kind == cpuCore_pkg::ldReg)
		|| (uop.kind == cpuCore_pkg::ldImm);

endmodule

// ==== source/registerFile.sv ====
`timescale 1ns/1ps
`include "cpuCore_macros.svh"

module registerFile
(
	input logic iClock,
	input logic rstN,
	input cpuCore_pkg::regIndexT srcIdx,
	output cpuCore_pkg::dataT srcData,
	output cpuCore_pkg::dataT accData,
	output cpuCore_pkg::dataT flags,
	input logic writeEn,
	input cpuCore_pkg::regIndexT writeIdx,
	input cpuCore_pkg::dataT writeData,
	input logic flagsEn,
	input cpuCore_pkg::dataT flagsData
);

	// Only Z and C are kept
	localparam cpuCore_pkg::dataT flagMask = cpuCore_pkg::dataT'((1 << `FLAG_Z) | (1 << `FLAG_C));

	cpuCore_pkg::dataT slotData [`REG_COUNT];
	cpuCore_pkg::dataT flagsReg;

	for (genvar i = 0; i < `REG_COUNT; i++)
	begin : gSlot
		if (i == `REG_HL)
		begin : gHole
			assign slotData[i] = '0; // (HL) has no storage
		end
		else
		begin : gReg
			cpuCore_pkg::dataT value;

			always_ff @(posedge iClock or negedge rstN)
			begin
				if (!rstN)
					value <= '0;
				else if (writeEn && writeIdx == cpuCore_pkg::regIndexT'(i))
					value <= writeData;
			end

			assign slotData[i] = value;
		end
	end

	always_ff @(posedge iClock or negedge rstN)
	begin
		if (!rstN)
			flagsReg <= '0;
		else if (flagsEn)
			flagsReg <= flagsData & flagMask;
	end

	assign srcData = slotData[srcIdx];
	assign accData = slotData[`REG_A];
	assign flags = flagsReg;

endmodule

// ==== decode/opcodeDecoder.sv ====
`timescale 1ns/1ps
`include "cpuCore_macros.svh"

module opcodeDecoder
(
	input logic iClock,
	input logic rstN,
	input cpuCore_pkg::dataT opcodeByte,
	input logic opcodeValid,
	output logic opcodeReady,
	output cpuCore_pkg::uopT uop,
	output logic uopValid,
	input logic uopReady
);

	typedef enum logic [1:0] {stBase, stPrefix, stImmediate} decStateT;

	decStateT state;
	cpuCore_pkg::dataT pendingOp; // Opcode of LD r,n waiting for its data byte
	cpuCore_pkg::uopT nextUop;
	logic isPrefix;
	logic isLdImm;
	logic byteAccepted;

	assign isPrefix = (state == stBase) && (opcodeByte == `CB_PREFIX);
	// 00rrr110 takes a data byte, (HL) included
	assign isLdImm = (state == stBase) && (opcodeByte[7:6] == 2'b00)
		&& (opcodeByte[2:0] == 3'b110);
	assign byteAccepted = opcodeValid && opcodeReady;

	// ----------------------------------------------------------
	// Multi-byte tracking
	always_ff @(posedge iClock or negedge rstN)
	begin
		if (!rstN)
			state <= stBase;
		else if (byteAccepted)
		begin
			if (isPrefix)
				state <= stPrefix;
			else if (isLdImm)
				state <= stImmediate;
			else
				state <= stBase; // Final byte ends the instruction
		end
	end

	always_ff @(posedge iClock)
	begin
		if (byteAccepted && isLdImm)
			pendingOp <= opcodeByte;
	end

	// ----------------------------------------------------------
	// Classification of the final byte
	always_comb
	begin
		nextUop = '0;
		nextUop.kind = cpuCore_pkg::illegal;
		nextUop.opcode = opcodeByte;
		nextUop.dst = opcodeByte[5:3];
		nextUop.src = opcodeByte[2:0];
		case (state)
			stImmediate:
			begin
				nextUop.opcode = pendingOp;
				nextUop.dst = pendingOp[5:3];
				nextUop.imm = opcodeByte;
				if (pendingOp[5:3] != `REG_HL)
					nextUop.kind = cpuCore_pkg::ldImm;
			end
			stPrefix:
			begin
				nextUop.cb = 1'b1;
				nextUop.dst = opcodeByte[2:0]; // Both CB forms work in place
				if (opcodeByte[2:0] == `REG_HL)
					nextUop.kind = cpuCore_pkg::illegal;
				else if (opcodeByte[7:3] == 5'b00010)
					nextUop.kind = cpuCore_pkg::rl;
				else if (opcodeByte[7:6] == 2'b01)
				begin
					nextUop.kind = cpuCore_pkg::bitTest;
					nextUop.bitSel = opcodeByte[5:3];
				end
			end
			default:
			begin
				if (opcodeByte[7:6] == 2'b01)
				begin
					// 0x76 lands here too and stays illegal
					if (opcodeByte[5:3] != `REG_HL && opcodeByte[2:0] != `REG_HL)
						nextUop.kind = cpuCore_pkg::ldReg;
				end
				else if (opcodeByte[7:4] == 4'hA && opcodeByte[2:0] != `REG_HL)
				begin
					nextUop.dst = `REG_A;
					nextUop.kind = opcodeByte[3] ? cpuCore_pkg::xorA : cpuCore_pkg::andA;
				end
			end
		endcase
	end

	// Prefix and first immediate byte go no further than the state register
	handshakeStage #(.payloadT(cpuCore_pkg::uopT)) u_uopStage
	(
		.iClock(iClock),
		.rstN(rstN),
		.inData(nextUop),
		.inValid(opcodeValid && !isPrefix && !isLdImm),
		.inReady(opcodeReady),
		.outData(uop),
		.outValid(uopValid),
		.outReady(uopReady)
	);

endmodule

// ==== source/handshakeStage.sv ====
`timescale 1ns/1ps

module handshakeStage
#(
	parameter type payloadT = logic [7:0]
)
(
	input logic iClock,
	input logic rstN,
	input payloadT inData,
	input logic inValid,
	output logic inReady,
	output payloadT outData,
	output logic outValid,
	input logic outReady
);

	payloadT dataReg;
	logic validReg;

	// Take a new item when empty or while the current one leaves
	assign inReady = !validReg || outReady;

	always_ff @(posedge iClock or negedge rstN)
	begin
		if (!rstN)
			validReg <= 1'b0;
		else if (inReady)
			validReg <= inValid;
	end

	always_ff @(posedge iClock)
	begin
		if (inValid && inReady)
			dataReg <= inData;
	end

	assign outData = dataReg;
	assign outValid = validReg;

endmodule

// ==== common/cpuCore_pkg.sv ====
`include "cpuCore_macros.svh"

package cpuCore_pkg;

	typedef logic [$clog2(`REG_COUNT)-1:0] regIndexT; // Register slot
	typedef logic [`DATA_WIDTH-1:0] dataT;

	// Micro-op kinds produced by the decoder
	typedef enum logic [2:0]
	{
		ldReg, // LD r,r'
		ldImm, // LD r,n
		andA, // AND r
		xorA, // XOR r
		rl, // CB RL r
		bitTest, // CB BIT b,r
		illegal
	} opKindT;

	// One micro-op per instruction
	typedef struct packed
	{
		opKindT kind;
		dataT opcode; // Opcode byte, after the prefix if any
		logic cb; // Prefix was seen
		regIndexT dst;
		regIndexT src;
		logic [2:0] bitSel; // Bit number for BIT
		dataT imm; // Data byte of LD r,n
	} uopT;

	// Output of an execution unit
	typedef struct packed
	{
		dataT value;
		dataT flags;
		logic writeReg; // Value goes to the register file
	} execResultT;

	// One record per retired instruction
	typedef struct packed
	{
		dataT opcode;
		logic cb;
		logic illegal;
		regIndexT dst;
		dataT value;
		dataT flags;
		logic writeReg;
	} retireT;

endpackage

// ==== common/cpuCore_macros.svh ====
`ifndef CPUCORE_MACROS_SVH
`define CPUCORE_MACROS_SVH

// Datapath sizes
`define DATA_WIDTH 8 // Registers and data bytes
`define REG_COUNT 8 // Operand slots B C D E H L (HL) A

// Register slots as encoded in the opcode
`define REG_HL 6 // Memory operand, not supported here
`define REG_A 7 // Accumulator

// Prefix byte for the extended table
`define CB_PREFIX 8'hCB

// Flag bit positions, all other bits read as zero
`define FLAG_Z 7
`define FLAG_C 4

`endif
